// File: perf_params.svh
`ifndef PERF_PARAMS_SVH
`define PERF_PARAMS_SVH

// Width of each event counter, a multiple of 4 for hex output
`define PERF_CNT_W 12

// Clock cycles between two report points
`define PERF_SAMPLE_PERIOD 120

// Reports issued after reset
`define PERF_SAMPLE_COUNT 3

// Bytes per text frame, three sections of tag plus two counts
`define PERF_FRAME_LEN 21

`endif

// File: perf_event_pkg.sv
`include "perf_params.svh"

package perf_event_pkg;

	localparam int NUM_EVENTS = 8;	// Strobes watched by the bank

	// Bit position of each strobe in the event vector
	typedef enum logic [2:0] {
		EV_L1I_READ  = 3'd0,
		EV_L1I_MISS  = 3'd1,
		EV_L1D_READ  = 3'd2,
		EV_L1D_WRITE = 3'd3,
		EV_L1D_MISS  = 3'd4,
		EV_L2_READ   = 3'd5,
		EV_L2_WRITE  = 3'd6,
		EV_L2_MISS   = 3'd7
	} event_e;

	// Wrapping event count
	typedef logic [`PERF_CNT_W-1:0] count_t;

endpackage

// File: perf_report_pkg.sv
package perf_report_pkg;

	// Cache level of a frame section, in frame order
	typedef enum logic [1:0] {
		LVL_L1I = 2'd0,
		LVL_L1D = 2'd1,
		LVL_L2  = 2'd2
	} level_e;

	typedef logic [7:0] byte_t;

	// Section tags
	localparam byte_t TAG_L1I = "a";
	localparam byte_t TAG_L1D = "b";
	localparam byte_t TAG_L2  = "c";

	// Bases for hex digits, upper case
	localparam byte_t CHR_DIGIT0 = "0";
	localparam byte_t CHR_HEX_A  = "A";

endpackage

// File: event_counter_bank.sv
`timescale 1ns/100ps

module event_counter_bank (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   read_l1i_i,
	input  logic                   miss_l1i_i,
	input  logic                   read_l1d_i,
	input  logic                   write_l1d_i,
	input  logic                   miss_l1d_i,
	input  logic                   read_l2_i,
	input  logic                   write_l2_i,
	input  logic                   miss_l2_i,
	output perf_event_pkg::count_t cnt_l1i_read_o,
	output perf_event_pkg::count_t cnt_l1i_miss_o,
	output perf_event_pkg::count_t cnt_l1d_miss_o,
	output perf_event_pkg::count_t cnt_l2_miss_o,
	output perf_event_pkg::count_t acc_l1d_o,
	output perf_event_pkg::count_t acc_l2_o
);

	logic [perf_event_pkg::NUM_EVENTS-1:0] ev_in;
	logic [perf_event_pkg::NUM_EVENTS-1:0] ev_prev;
	perf_event_pkg::count_t                cnt [perf_event_pkg::NUM_EVENTS];

	assign ev_in[perf_event_pkg::EV_L1I_READ]  = read_l1i_i;
	assign ev_in[perf_event_pkg::EV_L1I_MISS]  = miss_l1i_i;
	assign ev_in[perf_event_pkg::EV_L1D_READ]  = read_l1d_i;
	assign ev_in[perf_event_pkg::EV_L1D_WRITE] = write_l1d_i;
	assign ev_in[perf_event_pkg::EV_L1D_MISS]  = miss_l1d_i;
	assign ev_in[perf_event_pkg::EV_L2_READ]   = read_l2_i;
	assign ev_in[perf_event_pkg::EV_L2_WRITE]  = write_l2_i;
	assign ev_in[perf_event_pkg::EV_L2_MISS]   = miss_l2_i;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ev_prev <= '0;
		end else begin
			ev_prev <= ev_in;
		end
	end

	for (genvar i = 0; i < perf_event_pkg::NUM_EVENTS; i++) begin : g_cnt
		always_ff @(posedge clk) begin
			if (!rstn) begin
				cnt[i] <= '0;
			end else if (ev_in[i] && !ev_prev[i]) begin	// Rising edge only
				cnt[i] <= cnt[i] + 1'b1;
			end
		end
	end

	assign cnt_l1i_read_o = cnt[perf_event_pkg::EV_L1I_READ];
	assign cnt_l1i_miss_o = cnt[perf_event_pkg::EV_L1I_MISS];
	assign cnt_l1d_miss_o = cnt[perf_event_pkg::EV_L1D_MISS];
	assign cnt_l2_miss_o  = cnt[perf_event_pkg::EV_L2_MISS];

	// Access totals, wrap at counter width
	assign acc_l1d_o = perf_event_pkg::count_t'(cnt[perf_event_pkg::EV_L1D_READ]
		+ cnt[perf_event_pkg::EV_L1D_WRITE]);
	assign acc_l2_o  = perf_event_pkg::count_t'(cnt[perf_event_pkg::EV_L2_READ]
		+ cnt[perf_event_pkg::EV_L2_WRITE]);

endmodule

// File: sample_timer.sv
`timescale 1ns/100ps

`include "perf_params.svh"

module sample_timer (
	input  logic clk,
	input  logic rstn,
	output logic sample_o
);

	localparam logic [31:0] LAST_POINT = 32'(`PERF_SAMPLE_PERIOD * `PERF_SAMPLE_COUNT);

	logic [31:0] cyc_cnt;

	// Stops one past the last report point
	always_ff @(posedge clk) begin
		if (!rstn) begin
			cyc_cnt <= '0;
		end else if (cyc_cnt <= LAST_POINT) begin
			cyc_cnt <= cyc_cnt + 32'd1;
		end
	end

	always_comb begin
		sample_o = 1'b0;
		for (int k = 1; k <= `PERF_SAMPLE_COUNT; k++) begin
			if (cyc_cnt == 32'(k * `PERF_SAMPLE_PERIOD)) begin
				sample_o = 1'b1;
			end
		end
	end

endmodule

// File: report_serializer.sv
`timescale 1ns/100ps

`include "perf_params.svh"

module report_serializer (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   sample_i,
	input  perf_event_pkg::count_t cnt_l1i_read_i,
	input  perf_event_pkg::count_t cnt_l1i_miss_i,
	input  perf_event_pkg::count_t cnt_l1d_miss_i,
	input  perf_event_pkg::count_t acc_l1d_i,
	input  perf_event_pkg::count_t cnt_l2_miss_i,
	input  perf_event_pkg::count_t acc_l2_i,
	output perf_report_pkg::byte_t data_o,
	output logic                   wr_en_o
);

	localparam int DIGITS  = `PERF_CNT_W / 4;	// Hex digits per count
	localparam int SEC_LEN = 1 + 2 * DIGITS;	// Tag, miss, access
	localparam int IDX_W   = $clog2(`PERF_FRAME_LEN + 1);

	perf_event_pkg::count_t  snap_l1i_read;
	perf_event_pkg::count_t  snap_l1i_miss;
	perf_event_pkg::count_t  snap_l1d_miss;
	perf_event_pkg::count_t  snap_l1d_acc;
	perf_event_pkg::count_t  snap_l2_miss;
	perf_event_pkg::count_t  snap_l2_acc;
	logic [IDX_W-1:0]        idx;
	logic [IDX_W-1:0]        pos;
	perf_report_pkg::level_e lvl;
	perf_event_pkg::count_t  sec_miss;
	perf_event_pkg::count_t  sec_acc;
	perf_report_pkg::byte_t  next_byte;

	function automatic perf_report_pkg::byte_t hex_char(input logic [3:0] nib);
		if (nib < 4'd10) begin
			return perf_report_pkg::CHR_DIGIT0 + {4'h0, nib};
		end
		return perf_report_pkg::CHR_HEX_A + {4'h0, nib - 4'd10};
	endfunction

	// sel 0 picks the most significant digit
	function automatic logic [3:0] digit_of(input perf_event_pkg::count_t v, input int sel);
		return 4'(v >> (4 * (DIGITS - 1 - sel)));
	endfunction

	function automatic perf_report_pkg::byte_t tag_of(input perf_report_pkg::level_e l);
		case (l)
			perf_report_pkg::LVL_L1I: return perf_report_pkg::TAG_L1I;
			perf_report_pkg::LVL_L1D: return perf_report_pkg::TAG_L1D;
			default:                  return perf_report_pkg::TAG_L2;
		endcase
	endfunction

	always_ff @(posedge clk) begin
		if (sample_i) begin
			snap_l1i_read <= cnt_l1i_read_i;
			snap_l1i_miss <= cnt_l1i_miss_i;
			snap_l1d_miss <= cnt_l1d_miss_i;
			snap_l1d_acc  <= acc_l1d_i;
			snap_l2_miss  <= cnt_l2_miss_i;
			snap_l2_acc   <= acc_l2_i;
		end
	end

	// Split the byte index into section and offset
	always_comb begin
		if (idx < IDX_W'(SEC_LEN)) begin
			lvl = perf_report_pkg::LVL_L1I;
			pos = idx;
		end else if (idx < IDX_W'(2 * SEC_LEN)) begin
			lvl = perf_report_pkg::LVL_L1D;
			pos = idx - IDX_W'(SEC_LEN);
		end else begin
			lvl = perf_report_pkg::LVL_L2;
			pos = idx - IDX_W'(2 * SEC_LEN);
		end
	end

	always_comb begin
		case (lvl)
			perf_report_pkg::LVL_L1I: begin
				sec_miss = snap_l1i_miss;
				sec_acc  = snap_l1i_read;
			end
			perf_report_pkg::LVL_L1D: begin
				sec_miss = snap_l1d_miss;
				sec_acc  = snap_l1d_acc;
			end
			default: begin
				sec_miss = snap_l2_miss;
				sec_acc  = snap_l2_acc;
			end
		endcase
	end

	always_comb begin
		if (pos == '0) begin
			next_byte = tag_of(lvl);
		end else if (pos <= IDX_W'(DIGITS)) begin
			next_byte = hex_char(digit_of(sec_miss, int'(pos) - 1));
		end else begin
			next_byte = hex_char(digit_of(sec_acc, int'(pos) - 1 - DIGITS));
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			data_o  <= '0;
			wr_en_o <= 1'b0;
			idx     <= '0;
		end else if (sample_i) begin	// Restarts any frame in flight
			data_o  <= perf_report_pkg::TAG_L1I;
			wr_en_o <= 1'b1;
			idx     <= IDX_W'(1);
		end else if (wr_en_o) begin
			if (idx == IDX_W'(`PERF_FRAME_LEN)) begin
				wr_en_o <= 1'b0;	// Last byte stays on data_o
			end else begin
				data_o <= next_byte;
				idx    <= idx + 1'b1;
			end
		end
	end

endmodule

// File: cache_perf_monitor.sv
`timescale 1ns/100ps

module cache_perf_monitor (
	input  logic                   clk,
	input  logic                   rstn,
	input  logic                   read_l1i_i,
	input  logic                   miss_l1i_i,
	input  logic                   read_l1d_i,
	input  logic                   write_l1d_i,
	input  logic                   miss_l1d_i,
	input  logic                   read_l2_i,
	input  logic                   write_l2_i,
	input  logic                   miss_l2_i,
	output perf_report_pkg::byte_t data_o,
	output logic                   wr_en_o
);

	perf_event_pkg::count_t cnt_l1i_read;
	perf_event_pkg::count_t cnt_l1i_miss;
	perf_event_pkg::count_t cnt_l1d_miss;
	perf_event_pkg::count_t cnt_l2_miss;
	perf_event_pkg::count_t acc_l1d;
	perf_event_pkg::count_t acc_l2;
	logic                   sample;

	event_counter_bank u_counter_bank (
		.clk            (clk),
		.rstn           (rstn),
		.read_l1i_i     (read_l1i_i),
		.miss_l1i_i     (miss_l1i_i),
		.read_l1d_i     (read_l1d_i),
		.write_l1d_i    (write_l1d_i),
		.miss_l1d_i     (miss_l1d_i),
		.read_l2_i      (read_l2_i),
		.write_l2_i     (write_l2_i),
		.miss_l2_i      (miss_l2_i),
		.cnt_l1i_read_o (cnt_l1i_read),
		.cnt_l1i_miss_o (cnt_l1i_miss),
		.cnt_l1d_miss_o (cnt_l1d_miss),
		.cnt_l2_miss_o  (cnt_l2_miss),
		.acc_l1d_o      (acc_l1d),
		.acc_l2_o       (acc_l2)
	);

	sample_timer u_sample_timer (
		.clk      (clk),
		.rstn     (rstn),
		.sample_o (sample)
	);

	report_serializer u_serializer (
		.clk            (clk),
		.rstn           (rstn),
		.sample_i       (sample),
		.cnt_l1i_read_i (cnt_l1i_read),
		.cnt_l1i_miss_i (cnt_l1i_miss),
		.cnt_l1d_miss_i (cnt_l1d_miss),
		.acc_l1d_i      (acc_l1d),
		.cnt_l2_miss_i  (cnt_l2_miss),
		.acc_l2_i       (acc_l2),
		.data_o         (data_o),
		.wr_en_o        (wr_en_o)
	);

endmodule

// File: tb_report_model.sv
`timescale 1ns/100ps

`include "perf_params.svh"

module tb_report_model (
	input  logic       clk,
	input  logic       rstn,
	input  logic [7:0] ev_i,
	input  logic [7:0] data_i,
	input  logic       wr_en_i,
	output int         frames_o,
	output int         err_idle_o,
	output int         err_format_o,
	output int         err_digit_o,
	output int         err_edge_o,
	output int         err_charset_o,
	output int         err_extra_o,
	output int         letters_o
);

	localparam int LEN    = `PERF_FRAME_LEN;
	localparam int NREP   = `PERF_SAMPLE_COUNT;
	localparam int DIGITS = `PERF_CNT_W / 4;
	localparam int SEC    = 1 + 2 * DIGITS;	// Tag plus two counts
	localparam int MASK   = (1 << `PERF_CNT_W) - 1;

	int         cnt [8];
	logic [7:0] prev;
	int         cyc;
	int         reports;
	logic [7:0] exp_frame [NREP * LEN];
	int         rx_miss [NREP];	// L1I miss count read back from each frame
	int         rx_val;
	int         idx;
	logic       in_frame;
	logic       have_exp;

	function automatic logic [7:0] hex_char(input int n);
		if (n < 10) begin
			return 8'(48 + n);	// '0' upwards
		end
		return 8'(65 + n - 10);	// 'A' upwards
	endfunction

	function automatic int hex_val(input logic [7:0] b);
		if (b >= 8'h30 && b <= 8'h39) begin
			return int'(b) - 48;
		end
		if (b >= 8'h41 && b <= 8'h46) begin
			return int'(b) - 55;
		end
		return -1;
	endfunction

	task automatic put_section(input int base, input logic [7:0] tag, input int miss,
		input int acc);
		exp_frame[base] = tag;
		for (int d = 0; d < DIGITS; d++) begin
			exp_frame[base + 1 + d]          = hex_char((miss >> (4 * (DIGITS - 1 - d))) & 15);
			exp_frame[base + 1 + DIGITS + d] = hex_char((acc >> (4 * (DIGITS - 1 - d))) & 15);
		end
	endtask

	task automatic build_frame(input int f);
		int base;
		base = f * LEN;
		put_section(base, "a", cnt[perf_event_pkg::EV_L1I_MISS],
			cnt[perf_event_pkg::EV_L1I_READ]);
		put_section(base + SEC, "b", cnt[perf_event_pkg::EV_L1D_MISS],
			(cnt[perf_event_pkg::EV_L1D_READ] + cnt[perf_event_pkg::EV_L1D_WRITE]) & MASK);
		put_section(base + 2 * SEC, "c", cnt[perf_event_pkg::EV_L2_MISS],
			(cnt[perf_event_pkg::EV_L2_READ] + cnt[perf_event_pkg::EV_L2_WRITE]) & MASK);
	endtask

	task automatic check_byte();
		int         nib;
		logic [7:0] exp_b;
		nib = hex_val(data_i);
		if (nib < 0 && data_i !== "a" && data_i !== "b" && data_i !== "c") begin
			err_charset_o++;
			$display("FAILED at %0t: frame %0d byte %0d is %h, not a hex digit or tag",
				$time, frames_o, idx, data_i);
		end
		if (nib >= 10) begin
			letters_o++;
		end
		if (idx >= LEN) begin
			if (idx == LEN) begin
				err_format_o++;
				$display("FAILED at %0t: frame %0d runs past %0d bytes", $time, frames_o, LEN);
			end
			return;
		end
		if (idx >= 1 && idx <= DIGITS) begin
			rx_val = rx_val * 16 + ((nib < 0) ? 0 : nib);
			if (idx == DIGITS) begin
				rx_miss[frames_o] = rx_val;
			end
		end
		if (have_exp) begin
			exp_b = exp_frame[frames_o * LEN + idx];
			if (idx % SEC == 0) begin
				if (data_i !== exp_b) begin
					err_format_o++;
					$display("FAILED at %0t: frame %0d tag byte %0d is %h, expected %h",
						$time, frames_o, idx, data_i, exp_b);
				end
			end else if (data_i !== exp_b) begin
				err_digit_o++;
				$display("FAILED at %0t: frame %0d byte %0d is %h, expected %h",
					$time, frames_o, idx, data_i, exp_b);
			end
		end
	endtask

	initial begin
		frames_o      = 0;
		err_idle_o    = 0;
		err_format_o  = 0;
		err_digit_o   = 0;
		err_edge_o    = 0;
		err_charset_o = 0;
		err_extra_o   = 0;
		letters_o     = 0;
		reports       = 0;
		in_frame      = 1'b0;
		have_exp      = 1'b0;
		idx           = 0;
		rx_val        = 0;
	end

	always @(posedge clk) begin
		if (!rstn) begin
			prev    = '0;
			cyc     = 0;
			reports = 0;
			for (int i = 0; i < 8; i++) begin
				cnt[i] = 0;
			end
		end else begin
			// Snapshot takes the counts from before this edge
			if (reports < NREP && cyc == (reports + 1) * `PERF_SAMPLE_PERIOD) begin
				build_frame(reports);
				reports = reports + 1;
			end
			for (int i = 0; i < 8; i++) begin
				if (ev_i[i] && !prev[i]) begin
					cnt[i] = (cnt[i] + 1) & MASK;
				end
			end
			prev = ev_i;
			cyc  = cyc + 1;
		end
	end

	// Outputs are settled half a cycle after the edge
	always @(negedge clk) begin
		if (wr_en_i === 1'b1) begin
			if (!in_frame) begin
				in_frame = 1'b1;
				idx      = 0;
				rx_val   = 0;
				have_exp = (frames_o < reports);
				if (frames_o >= NREP) begin
					err_extra_o++;
					$display("FAILED at %0t: frame %0d starts after the last report",
						$time, frames_o);
				end else if (!have_exp) begin
					if (reports == 0) begin
						err_idle_o++;
					end else begin
						err_format_o++;
					end
					$display("FAILED at %0t: frame %0d starts before its report point",
						$time, frames_o);
				end
			end
			if (frames_o < NREP) begin
				check_byte();
			end
			idx++;
		end else if (in_frame) begin
			if (frames_o < NREP && idx != LEN) begin
				err_format_o++;
				$display("FAILED at %0t: frame %0d has %0d bytes, expected %0d",
					$time, frames_o, idx, LEN);
			end
			if (frames_o == 1 && ((rx_miss[1] - rx_miss[0]) & MASK) != 1) begin	// Held line
				err_edge_o++;
				$display("FAILED at %0t: held L1I miss line counted %0d events, expected 1",
					$time, (rx_miss[1] - rx_miss[0]) & MASK);
			end
			frames_o++;
			in_frame = 1'b0;
		end else if (wr_en_i !== 1'b0 || (reports == 0 && data_i !== 8'h00)) begin
			if (reports == 0) begin
				err_idle_o++;
			end else begin
				err_extra_o++;
			end
			$display("FAILED at %0t: idle output wr_en_o=%b data_o=%h", $time, wr_en_i, data_i);
		end
	end

endmodule

// File: tb_cache_perf_monitor.sv
`timescale 1ns/100ps

`include "perf_params.svh"

module tb_cache_perf_monitor;

	localparam int PERIOD     = `PERF_SAMPLE_PERIOD;
	localparam int NREP       = `PERF_SAMPLE_COUNT;
	localparam int WD_CYCLES  = (NREP + 1) * PERIOD + 50;
	localparam int HOLD_START = PERIOD + 30;	// Long pulse in the second interval
	localparam int HOLD_END   = PERIOD + 90;

	logic       clk;
	logic       rstn;
	logic [7:0] ev;
	logic [7:0] dut_data;
	logic       dut_wr_en;
	int         seed;
	int         n_pass;
	int         n_fail;
	int         frames;
	int         err_idle;
	int         err_format;
	int         err_digit;
	int         err_edge;
	int         err_charset;
	int         err_extra;
	int         letters;

	cache_perf_monitor uut (
		.clk         (clk),
		.rstn        (rstn),
		.read_l1i_i  (ev[perf_event_pkg::EV_L1I_READ]),
		.miss_l1i_i  (ev[perf_event_pkg::EV_L1I_MISS]),
		.read_l1d_i  (ev[perf_event_pkg::EV_L1D_READ]),
		.write_l1d_i (ev[perf_event_pkg::EV_L1D_WRITE]),
		.miss_l1d_i  (ev[perf_event_pkg::EV_L1D_MISS]),
		.read_l2_i   (ev[perf_event_pkg::EV_L2_READ]),
		.write_l2_i  (ev[perf_event_pkg::EV_L2_WRITE]),
		.miss_l2_i   (ev[perf_event_pkg::EV_L2_MISS]),
		.data_o      (dut_data),
		.wr_en_o     (dut_wr_en)
	);

	tb_report_model u_model (
		.clk           (clk),
		.rstn          (rstn),
		.ev_i          (ev),
		.data_i        (dut_data),
		.wr_en_i       (dut_wr_en),
		.frames_o      (frames),
		.err_idle_o    (err_idle),
		.err_format_o  (err_format),
		.err_digit_o   (err_digit),
		.err_edge_o    (err_edge),
		.err_charset_o (err_charset),
		.err_extra_o   (err_extra),
		.letters_o     (letters)
	);

	function automatic bit quiet_cycle(input int c);
		for (int k = 1; k <= NREP; k++) begin
			if (c >= k * PERIOD - 4 && c <= k * PERIOD) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	task automatic drive_cycle(input int c);
		logic [7:0] nxt;
		nxt = ev;
		for (int i = 0; i < 8; i++) begin
			if ($random(seed) & 1) begin
				nxt[i] = ~nxt[i];	// Toggle with probability one half
			end
		end
		if (c > PERIOD && c <= 2 * PERIOD) begin
			nxt[perf_event_pkg::EV_L1I_MISS] = (c >= HOLD_START && c < HOLD_END);
		end
		if (quiet_cycle(c)) begin
			nxt = '0;
		end
		ev = nxt;
	endtask

	task automatic report_test(input string name, input int errs);
		if (errs == 0) begin
			n_pass++;
			$display("test %s: pass", name);
		end else begin
			n_fail++;
			$display("test %s: fail, %0d errors", name, errs);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", WD_CYCLES);
		$display("TB FAILED");
		$finish;
	end

	// Cycle 0 is the first cycle after reset release
	initial begin : stimulus
		int c;
		@(posedge rstn);
		c = 0;
		forever begin
			drive_cycle(c);
			@(posedge clk);
			#2;
			c++;
		end
	end

	initial begin
		seed   = 71;
		rstn   = 1'b0;
		ev     = '0;
		n_pass = 0;
		n_fail = 0;
		repeat (4) @(posedge clk);
		#2;
		rstn = 1'b1;

		wait (frames >= 1);
		report_test("idle output before first report", err_idle);
		wait (frames >= 2);
		report_test("edge counting on a held line", err_edge);
		wait (frames >= NREP);
		report_test("frame length and tags", err_format);
		report_test("hex digits against model", err_digit);
		if (letters == 0) begin
			$display("No digit above 9 was received, so upper-case letters were never seen");
		end
		report_test("character set", err_charset + int'(letters == 0));

		repeat (PERIOD) @(posedge clk);	// No further frame may start
		report_test("frame count and quiet end", err_extra + int'(frames != NREP));

		$display("tests passed: %0d, failed: %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// File: src.f
+incdir+.
perf_event_pkg.sv
perf_report_pkg.sv
event_counter_bank.sv
sample_timer.sv
report_serializer.sv
cache_perf_monitor.sv
tb_report_model.sv
tb_cache_perf_monitor.sv

// File: Bender.yml
package:
  name: cache_perf_monitor

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - perf_event_pkg.sv
      - perf_report_pkg.sv
      - event_counter_bank.sv
      - sample_timer.sv
      - report_serializer.sv
      - cache_perf_monitor.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_report_model.sv
      - tb_cache_perf_monitor.sv
